/* source/ecc_pkg.sv */
package ecc_pkg;

    ////////////////////////////////////////////////////////////
    // Code geometry
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH   = 113;
    localparam int PARITY_WIDTH = 8;
    localparam int PIPE_LATENCY = 2;                 // Input reg plus output reg

    localparam int COL_LOW_WIDTH = PARITY_WIDTH - 1; // Hamming part of a column
    localparam int COL_FIRST     = 3;                // Smallest weight-2 value
    localparam int COL_LIMIT     = 1 << COL_LOW_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    ////////////////////////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////////////////////////

    // Word as received from storage or link
    typedef struct packed {
        data_t   data;
        parity_t parity;
        logic    bypass;   // Pass data through, no flags
    } ecc_word_t;

    // Checked word returned to the consumer
    typedef struct packed {
        data_t   data;      // Corrected unless bypassed
        parity_t parity;    // Regenerated from received data
        logic    sbit_err;
        logic    dbit_err;
    } ecc_result_t;

    ////////////////////////////////////////////////////////////
    // Check matrix
    ////////////////////////////////////////////////////////////

    // Data bit idx takes the idx-th low value that is neither zero nor
    // a power of two, counting up from 3. The top bit then makes the
    // column weight odd, so every data column has weight 3 or more and
    // a double error can never alias a single one.
    function automatic parity_t check_column(input int unsigned idx);
        parity_t                  col;
        logic [COL_LOW_WIDTH-1:0] low;
        int unsigned              n;
        col = '0;
        n   = 0;
        for (int v = COL_FIRST; v < COL_LIMIT; v++) begin
            low = v[COL_LOW_WIDTH-1:0];
            if ((low & (low - 1'b1)) != '0) begin  // Skip powers of two
                if (n == idx) begin
                    col[COL_LOW_WIDTH-1:0]  = low;
                    col[PARITY_WIDTH-1]     = ~^low;  // Even low weight gets top bit
                end
                n++;
            end
        end
        return col;
    endfunction

endpackage

/* source/ecc_encoder.sv */
module ecc_encoder (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);
    import ecc_pkg::*;

    ////////////////////////////////////////////////////////////
    // Row masks of the check matrix
    ////////////////////////////////////////////////////////////

    // Collects, for one check bit, every data bit whose column has it set
    function automatic data_t row_mask(input int unsigned bit_idx);
        data_t   mask;
        parity_t col;
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            col     = check_column(i);
            mask[i] = col[bit_idx];
        end
        return mask;
    endfunction

    ////////////////////////////////////////////////////////////
    // Parity trees
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < PARITY_WIDTH; k++) begin : g_row
        localparam data_t ROW = row_mask(k);  // Folded at elaboration

        assign parity[k] = ^(data & ROW);     // One XOR tree per check bit
    end

endmodule

/* source/ecc_syndrome_decoder.sv */
module ecc_syndrome_decoder (
    input  ecc_pkg::parity_t syndrome,
    output ecc_pkg::data_t   flip_mask,
    output logic             sbit_err,
    output logic             dbit_err
);
    import ecc_pkg::*;

    logic    synd_zero;
    logic    synd_onehot;
    logic    data_hit;
    parity_t synd_minus_one;

    ////////////////////////////////////////////////////////////
    // Data column match
    ////////////////////////////////////////////////////////////

    // Columns are distinct, so at most one bit of the mask can be set
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_col
        localparam parity_t COL = check_column(i);

        assign flip_mask[i] = (syndrome == COL);
    end

    assign data_hit = |flip_mask;

    ////////////////////////////////////////////////////////////
    // Error class
    ////////////////////////////////////////////////////////////

    assign synd_zero      = (syndrome == '0);
    assign synd_minus_one = syndrome - 1'b1;
    assign synd_onehot    = !synd_zero && ((syndrome & synd_minus_one) == '0);  // Check bit hit

    // A one-hot syndrome flags the check field only, data stays as is
    assign sbit_err = data_hit | synd_onehot;
    assign dbit_err = !synd_zero && !data_hit && !synd_onehot;  // Even weight or unused code

endmodule

/* source/ecc_codec.sv */
module ecc_codec (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  ecc_pkg::ecc_word_t  in_word,
    output logic                out_valid,
    output ecc_pkg::ecc_result_t out_result
);
    import ecc_pkg::*;

    logic        s1_valid;
    ecc_word_t   s1_word;
    parity_t     gen_parity;
    parity_t     syndrome;
    data_t       flip_mask;
    logic        dec_sbit;
    logic        dec_dbit;
    ecc_result_t s2_next;

    ////////////////////////////////////////////////////////////
    // Stage 1 input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_word <= in_word;  // Holds when idle
        end
    end

    ////////////////////////////////////////////////////////////
    // Check and correct
    ////////////////////////////////////////////////////////////

    ecc_encoder u_encoder (
        .data   (s1_word.data),
        .parity (gen_parity)
    );

    assign syndrome = gen_parity ^ s1_word.parity;

    ecc_syndrome_decoder u_decoder (
        .syndrome  (syndrome),
        .flip_mask (flip_mask),
        .sbit_err  (dec_sbit),
        .dbit_err  (dec_dbit)
    );

    always_comb begin
        s2_next.parity = gen_parity;  // Reported even under bypass
        if (s1_word.bypass) begin
            s2_next.data     = s1_word.data;
            s2_next.sbit_err = 1'b0;
            s2_next.dbit_err = 1'b0;
        end else begin
            s2_next.data     = s1_word.data ^ flip_mask;
            s2_next.sbit_err = dec_sbit;
            s2_next.dbit_err = dec_dbit;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_result <= s2_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Pipeline comes out of reset empty
    a_idle_after_rst: assert property (
        @(posedge clk) rst |=> !out_valid
    );

    // Decoder classes stay exclusive through the output register
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !(out_result.sbit_err && out_result.dbit_err)
    );

endmodule

/* verif/ecc_checker.sv */
module ecc_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  ecc_pkg::ecc_word_t   in_word,
    input  logic                 out_valid,
    input  ecc_pkg::ecc_result_t out_result,
    output int unsigned          check_count,
    output int unsigned          error_count,
    output int unsigned          pending
);
    import ecc_pkg::*;

    ecc_result_t exp_q[$];        // Expected results in issue order
    int unsigned due_q[$];        // Cycle in which each result is due
    parity_t     col_table [DATA_WIDTH];
    int unsigned cycle    = 0;
    int unsigned n_checked = 0;
    int unsigned n_errors  = 0;
    logic        rst_d    = 1'b0;

    assign check_count = n_checked;
    assign error_count = n_errors;
    assign pending     = exp_q.size();

    initial begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            col_table[i] = check_column(i);
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic ecc_result_t expected_result(input ecc_word_t w);
        ecc_result_t r;
        parity_t     syn;
        int          hit;
        r.parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (w.data[i]) begin
                r.parity ^= col_table[i];
            end
        end
        syn = r.parity ^ w.parity;
        hit = -1;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (col_table[i] == syn) begin
                hit = i;
            end
        end
        r.data     = w.data;
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        if (syn != '0) begin
            if (hit >= 0) begin
                r.data[hit] = ~r.data[hit];  // Data-bit single
                r.sbit_err  = 1'b1;
            end else if ($countones(syn) == 1) begin
                r.sbit_err = 1'b1;           // Check-bit single
            end else begin
                r.dbit_err = 1'b1;
            end
        end
        if (w.bypass) begin
            r.data     = w.data;
            r.sbit_err = 1'b0;
            r.dbit_err = 1'b0;
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %0h got %0h at cycle %0d", name, exp, act, cycle);
            n_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : scoreboard
        ecc_result_t exp;
        int unsigned due;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output valid at cycle %0d with no word outstanding", cycle);
                n_errors++;
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) begin
                    $display("Result came at cycle %0d but was due at cycle %0d", cycle, due);
                    n_errors++;
                end
                compare_field("data", exp.data, out_result.data);
                compare_field("parity", exp.parity, out_result.parity);
                compare_field("sbit_err", exp.sbit_err, out_result.sbit_err);
                compare_field("dbit_err", exp.dbit_err, out_result.dbit_err);
                n_checked++;
            end
        end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
            $display("Result due at cycle %0d never came out", due_q[0]);
            n_errors++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
        if (rst_d && out_valid) begin
            $display("Output valid was high in the cycle after reset");
            n_errors++;
        end
        if (rst) begin
            exp_q.delete();   // Words in flight are dropped by reset
            due_q.delete();
        end else if (in_valid) begin
            exp_q.push_back(expected_result(in_word));
            due_q.push_back(cycle + PIPE_LATENCY);
        end
        rst_d = rst;
        cycle++;
    end

endmodule

/* verif/tb_ecc_codec.sv */
module tb_ecc_codec;
    import ecc_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int N_CLEAN       = 40;
    localparam int N_DOUBLE      = 40;
    localparam int N_BYPASS      = 20;
    localparam int N_TIMING      = 30;
    localparam int TOTAL_WORDS   = N_CLEAN + DATA_WIDTH + PARITY_WIDTH + N_DOUBLE
                                   + N_BYPASS + N_TIMING;
    localparam int MARGIN_CYCLES = 400;  // Reset, gaps and drain per test
    localparam int CODE_BITS     = DATA_WIDTH + PARITY_WIDTH;

    logic        clk;
    logic        rst;
    logic        in_valid;
    ecc_word_t   in_word;
    logic        out_valid;
    ecc_result_t out_result;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned pending;
    int unsigned test_checks;
    int unsigned test_errors;

    ecc_codec DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    ecc_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .check_count (check_count),
        .error_count (error_count),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((TOTAL_WORDS + PIPE_LATENCY + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Word builders
    ////////////////////////////////////////////////////////////

    function automatic data_t random_data();
        logic [127:0] raw;
        for (int j = 0; j < 4; j++) begin
            raw[32*j +: 32] = $urandom;
        end
        return raw[DATA_WIDTH-1:0];
    endfunction

    function automatic ecc_word_t clean_word();
        ecc_word_t w;
        w.data   = random_data();
        w.parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (w.data[i]) begin
                w.parity ^= check_column(i);
            end
        end
        w.bypass = 1'b0;
        return w;
    endfunction

    // Positions past the data field address the check bits
    function automatic ecc_word_t flip_bit(input ecc_word_t w, input int pos);
        if (pos < DATA_WIDTH) begin
            w.data[pos] = ~w.data[pos];
        end else begin
            w.parity[pos-DATA_WIDTH] = ~w.parity[pos-DATA_WIDTH];
        end
        return w;
    endfunction

    function automatic ecc_word_t double_error(input ecc_word_t w);
        int p1;
        int p2;
        p1 = $urandom_range(CODE_BITS - 1, 0);
        p2 = p1;
        while (p2 == p1) begin
            p2 = $urandom_range(CODE_BITS - 1, 0);
        end
        return flip_bit(flip_bit(w, p1), p2);
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic send_word(input ecc_word_t w);
        @(negedge clk);
        in_valid = 1'b1;
        in_word  = w;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic begin_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        while (pending != 0) begin
            @(negedge clk);
        end
        $display("%-14s %0d words checked, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        ecc_word_t w;
        void'($urandom(62141));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        begin_test();
        for (int n = 0; n < N_CLEAN; n++) begin
            send_word(clean_word());
        end
        end_test("clean");

        begin_test();
        for (int i = 0; i < DATA_WIDTH; i++) begin
            send_word(flip_bit(clean_word(), i));
        end
        end_test("data single");

        begin_test();
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            send_word(flip_bit(clean_word(), DATA_WIDTH + k));
        end
        end_test("check single");

        begin_test();
        for (int n = 0; n < N_DOUBLE; n++) begin
            send_word(double_error(clean_word()));
        end
        end_test("double");

        begin_test();
        for (int n = 0; n < N_BYPASS; n++) begin
            w = clean_word();
            if (n % 2 == 0) begin
                w = flip_bit(w, $urandom_range(CODE_BITS - 1, 0));
            end else begin
                w = double_error(w);
            end
            w.bypass = 1'b1;
            send_word(w);
        end
        end_test("bypass");

        begin_test();
        for (int n = 0; n < N_TIMING; n++) begin
            if (n == N_TIMING / 2) begin
                @(negedge clk);
                rst     = 1'b1;               // Pulse with words in flight
                in_word = clean_word();
                repeat (2) @(negedge clk);
                rst      = 1'b0;
                in_valid = 1'b0;
            end
            send_word(clean_word());
            if (n % 4 == 3) begin
                idle_cycles($urandom_range(2, 1));
            end
        end
        end_test("timing");

        $display("Summary: %0d words checked, %0d errors", check_count, error_count);
        if (error_count == 0 && pending == 0 && check_count != 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
source/ecc_pkg.sv
source/ecc_encoder.sv
source/ecc_syndrome_decoder.sv
source/ecc_codec.sv
verif/ecc_checker.sv
verif/tb_ecc_codec.sv
